// ==== design/seq_defines.svh ====
`ifndef SEQ_DEFINES_SVH
`define SEQ_DEFINES_SVH

// Sequencer cores sharing the command memory.
`define N_CORES 2

// Word address into the 128-bit command memory.
`define CMD_ADDR_WIDTH 6

// Words per core region. Core i starts at word i*CORE_REGION.
`define CORE_REGION 32

// Per-core time counter.
`define TCNT_WIDTH 32

// Control and status register, just past the command words.
`define CTRL_ADDR 12'h400

`endif

// ==== design/pulse_pkg.sv ====
package pulse_pkg;

	typedef enum logic [3:0] {
		OP_HALT  = 4'h0,
		OP_PULSE = 4'h1
	} cmd_op_e;

	typedef struct packed {
		cmd_op_e     op;
		logic [31:0] timestamp;
		logic [23:0] env_word;
		logic [16:0] phase;
		logic [8:0]  freq;
		logic [15:0] amp;
		logic [3:0]  cfg;
		logic [21:0] reserved;
	} pulse_cmd_t;

	typedef struct packed {
		logic [23:0] env_word;
		logic [16:0] phase;
		logic [8:0]  freq;
		logic [15:0] amp;
		logic [3:0]  cfg;
	} pulse_t;

	// Low cfg bits. The value 3 selects no element.
	typedef enum logic [1:0] {
		QDRV = 2'd0,
		RDRV = 2'd1,
		RDLO = 2'd2
	} elem_sel_e;

	typedef struct packed {
		logic [1:0]  mode;
		logic [9:0]  envstart;
		logic [9:0]  envlength;
		logic [15:0] ampx;
		logic [8:0]  freqaddr;
		logic [16:0] pini;
	} qdrv_elem_t;

	// Readout drive and readout LO share this layout.
	typedef struct packed {
		logic [1:0]  mode;
		logic [11:0] envstart;
		logic [11:0] envlength;
		logic [15:0] ampx;
		logic [8:0]  freqaddr;
		logic [16:0] pini;
	} rdrv_elem_t;

endpackage

// ==== design/bus_pkg.sv ====
`include "seq_defines.svh"

package bus_pkg;
	import pulse_pkg::*;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic [31:0] prdata;
		logic        pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic                       valid;
		logic [`CMD_ADDR_WIDTH-1:0] addr;
	} mem_rd_req_t;

	typedef struct packed {
		logic       valid;
		pulse_cmd_t data;
	} mem_rd_rsp_t;

endpackage

// ==== design/cmd_mem.sv ====
`include "seq_defines.svh"

module cmd_mem import bus_pkg::*; (
	input  logic                dspif,
	input  logic                reset,
	input  apb_req_t            apb_req,
	output apb_rsp_t            apb_rsp,
	input  mem_rd_req_t         rd_req,
	output mem_rd_rsp_t         rd_rsp,
	input  logic [`N_CORES-1:0] done,
	output logic                start
);
	logic [127:0] mem [2**`CMD_ADDR_WIDTH];
	logic setup;
	logic access;
	logic in_mem;
	logic is_ctrl;
	logic [`CMD_ADDR_WIDTH-1:0] word;
	logic [1:0] lane;
	logic [31:0] prdata_q;
	logic rd_valid_q;
	logic [127:0] rd_data_q;

	assign setup = apb_req.psel & ~apb_req.penable;
	assign access = apb_req.psel & apb_req.penable;
	assign in_mem = (apb_req.paddr >> (`CMD_ADDR_WIDTH + 4)) == 12'd0;
	assign is_ctrl = apb_req.paddr == `CTRL_ADDR;
	assign word = apb_req.paddr[`CMD_ADDR_WIDTH+3:4];
	assign lane = apb_req.paddr[3:2]; // Lane 3 is the top of the word.

	always_ff @(posedge dspif) begin
		if (access && apb_req.pwrite && in_mem) begin
			mem[word][lane*32 +: 32] <= apb_req.pwdata;
		end
	end

	// Read data is fetched in the setup phase, ready for the access phase.
	always_ff @(posedge dspif) begin
		rd_data_q <= mem[rd_req.addr];
		if (setup) begin
			prdata_q <= is_ctrl ? 32'(done) : mem[word][lane*32 +: 32];
		end
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			start <= 1'b0;
			rd_valid_q <= 1'b0;
		end else begin
			start <= access && apb_req.pwrite && is_ctrl && apb_req.pwdata[0];
			rd_valid_q <= rd_req.valid;
		end
	end

	assign apb_rsp = '{pready: access, prdata: prdata_q, pslverr: access && !in_mem && !is_ctrl};
	assign rd_rsp = '{valid: rd_valid_q, data: rd_data_q};

endmodule

// ==== design/cmd_arbiter.sv ====
`include "seq_defines.svh"

module cmd_arbiter import bus_pkg::*; (
	input  logic                dspif,
	input  logic                reset,
	input  mem_rd_req_t         core_req [`N_CORES],
	output logic [`N_CORES-1:0] core_grant,
	output mem_rd_rsp_t         core_rsp [`N_CORES],
	output mem_rd_req_t         mem_req,
	input  mem_rd_rsp_t         mem_rsp
);
	localparam int IDX_W = $clog2(`N_CORES);

	logic [IDX_W-1:0] last_q; // Last winner, also owner of this cycle's response.
	logic [IDX_W-1:0] win;
	logic found;

	// Search starts at the core after the last winner.
	always_comb begin
		int idx;
		win = last_q;
		found = 1'b0;
		for (int k = 1; k <= `N_CORES; k++) begin
			idx = (int'(last_q) + k) % `N_CORES;
			if (!found && core_req[idx].valid) begin
				win = IDX_W'(idx);
				found = 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `N_CORES; i++) begin
			core_grant[i] = found && (win == IDX_W'(i));
			core_rsp[i] = '{
				valid: mem_rsp.valid && (last_q == IDX_W'(i)),
				data:  mem_rsp.data
			};
		end
	end

	assign mem_req = '{valid: found, addr: core_req[win].addr};

	always_ff @(posedge dspif) begin
		if (reset) begin
			last_q <= IDX_W'(`N_CORES - 1); // Core 0 goes first.
		end else if (found) begin
			last_q <= win;
		end
	end

endmodule

// ==== design/pulse_core.sv ====
`include "seq_defines.svh"

module pulse_core import bus_pkg::*, pulse_pkg::*; #(
	parameter int CORE_ID = 0
) (
	input  logic        dspif,
	input  logic        reset,
	input  logic        start,
	output mem_rd_req_t rd_req,
	input  logic        grant,
	input  mem_rd_rsp_t rd_rsp,
	output pulse_t      pulse,
	output logic        pulse_stb,
	output logic        done
);
	localparam int OFF_W = $clog2(`CORE_REGION);
	localparam logic [`CMD_ADDR_WIDTH-1:0] BASE = `CMD_ADDR_WIDTH'(CORE_ID * `CORE_REGION);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_WAIT,
		S_READY,
		S_DONE
	} state_e;

	state_e state;
	logic [OFF_W-1:0] off_q;
	logic [`TCNT_WIDTH-1:0] tcnt;
	pulse_cmd_t cmd_q;
	logic is_pulse;
	logic fire;

	assign is_pulse = cmd_q.op == OP_PULSE;
	// A stale timestamp fires as soon as the command is in.
	assign fire = (state == S_READY) && is_pulse && (tcnt >= cmd_q.timestamp);

	always_ff @(posedge dspif) begin
		if (reset || start) begin
			tcnt <= '0;
		end else begin
			tcnt <= tcnt + 1'b1;
		end
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			state <= S_IDLE;
			off_q <= '0;
		end else if (start) begin
			state <= S_FETCH;
			off_q <= '0;
		end else begin
			case (state)
				S_FETCH: if (grant) state <= S_WAIT;
				S_WAIT: if (rd_rsp.valid) state <= S_READY;
				S_READY: begin
					if (!is_pulse) begin
						state <= S_DONE; // Unknown opcodes halt too.
					end else if (fire) begin
						off_q <= off_q + 1'b1;
						state <= (off_q == OFF_W'(`CORE_REGION - 1)) ? S_DONE : S_FETCH;
					end
				end
				default: state <= state;
			endcase
		end
	end

	always_ff @(posedge dspif) begin
		if (state == S_WAIT && rd_rsp.valid) begin
			cmd_q <= rd_rsp.data;
		end
	end

	assign rd_req = '{valid: state == S_FETCH, addr: BASE + `CMD_ADDR_WIDTH'(off_q)};
	assign pulse = '{
		env_word: cmd_q.env_word,
		phase:    cmd_q.phase,
		freq:     cmd_q.freq,
		amp:      cmd_q.amp,
		cfg:      cmd_q.cfg
	};
	assign pulse_stb = fire;
	assign done = state == S_DONE;

endmodule

// ==== design/elem_router.sv ====
module elem_router import pulse_pkg::*; (
	input  logic       dspif,
	input  logic       reset,
	input  pulse_t     pulse,
	input  logic       pulse_stb,
	output qdrv_elem_t qdrv,
	output logic       qdrv_stb,
	output rdrv_elem_t rdrv,
	output logic       rdrv_stb,
	output rdrv_elem_t rdlo,
	output logic       rdlo_stb
);
	elem_sel_e sel;
	qdrv_elem_t qdrv_next;
	rdrv_elem_t rd_next;

	assign sel = elem_sel_e'(pulse.cfg[1:0]);

	assign qdrv_next = '{
		mode:      pulse.cfg[3:2],
		envstart:  pulse.env_word[9:0],
		envlength: pulse.env_word[21:12],
		ampx:      pulse.amp,
		freqaddr:  pulse.freq,
		pini:      pulse.phase
	};

	// Readout elements take the wider envelope slices.
	assign rd_next = '{
		mode:      pulse.cfg[3:2],
		envstart:  pulse.env_word[11:0],
		envlength: pulse.env_word[23:12],
		ampx:      pulse.amp,
		freqaddr:  pulse.freq,
		pini:      pulse.phase
	};

	always_ff @(posedge dspif) begin
		if (reset) begin
			qdrv_stb <= 1'b0;
			rdrv_stb <= 1'b0;
			rdlo_stb <= 1'b0;
		end else begin
			qdrv_stb <= pulse_stb && (sel == QDRV);
			rdrv_stb <= pulse_stb && (sel == RDRV);
			rdlo_stb <= pulse_stb && (sel == RDLO);
		end
	end

	always_ff @(posedge dspif) begin
		if (pulse_stb) begin
			case (sel)
				QDRV: qdrv <= qdrv_next;
				RDRV: rdrv <= rd_next;
				RDLO: rdlo <= rd_next;
				default: ; // Selector 3 drops the pulse.
			endcase
		end
	end

endmodule

// ==== design/seq_top.sv ====
`include "seq_defines.svh"

module seq_top import bus_pkg::*, pulse_pkg::*; (
	input  logic                dspif,
	input  logic                reset,
	input  apb_req_t            apb_req,
	output apb_rsp_t            apb_rsp,
	output qdrv_elem_t          qdrv [`N_CORES],
	output logic [`N_CORES-1:0] qdrv_stb,
	output rdrv_elem_t          rdrv [`N_CORES],
	output logic [`N_CORES-1:0] rdrv_stb,
	output rdrv_elem_t          rdlo [`N_CORES],
	output logic [`N_CORES-1:0] rdlo_stb
);
	logic start;
	logic [`N_CORES-1:0] done;
	logic [`N_CORES-1:0] grant;
	logic [`N_CORES-1:0] pulse_stb;
	mem_rd_req_t core_req [`N_CORES];
	mem_rd_rsp_t core_rsp [`N_CORES];
	mem_rd_req_t mem_req;
	mem_rd_rsp_t mem_rsp;
	pulse_t pulse [`N_CORES];

	cmd_mem i_mem (
		.dspif(dspif),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.rd_req(mem_req),
		.rd_rsp(mem_rsp),
		.done(done),
		.start(start)
	);

	cmd_arbiter i_arb (
		.dspif(dspif),
		.reset(reset),
		.core_req(core_req),
		.core_grant(grant),
		.core_rsp(core_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	for (genvar i = 0; i < `N_CORES; i++) begin : g_core
		pulse_core #(.CORE_ID(i)) i_core (
			.dspif(dspif),
			.reset(reset),
			.start(start),
			.rd_req(core_req[i]),
			.grant(grant[i]),
			.rd_rsp(core_rsp[i]),
			.pulse(pulse[i]),
			.pulse_stb(pulse_stb[i]),
			.done(done[i])
		);

		elem_router i_router (
			.dspif(dspif),
			.reset(reset),
			.pulse(pulse[i]),
			.pulse_stb(pulse_stb[i]),
			.qdrv(qdrv[i]),
			.qdrv_stb(qdrv_stb[i]),
			.rdrv(rdrv[i]),
			.rdrv_stb(rdrv_stb[i]),
			.rdlo(rdlo[i]),
			.rdlo_stb(rdlo_stb[i])
		);
	end

endmodule

// ==== verif/seq_tb.sv ====
`include "seq_defines.svh"

module seq_tb import bus_pkg::*, pulse_pkg::*; ();
	localparam int MAX_TS = 200; // Largest timestamp in any program.
	localparam int N_TESTS = 6;
	localparam int POLL_LIMIT = (MAX_TS + 200) / 4;

	typedef struct packed {
		int          chan;
		logic [67:0] data;
		int          lo;
		int          hi;
	} exp_t;

	logic dspif;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	qdrv_elem_t qdrv [`N_CORES];
	logic [`N_CORES-1:0] qdrv_stb;
	rdrv_elem_t rdrv [`N_CORES];
	logic [`N_CORES-1:0] rdrv_stb;
	rdrv_elem_t rdlo [`N_CORES];
	logic [`N_CORES-1:0] rdlo_stb;

	int seed;
	int cyc;
	int start_cyc;
	int errors;
	int passed;
	int test_errors;
	pulse_cmd_t prog [`N_CORES][$];
	exp_t exp_q [`N_CORES][$];
	string chan_name [3] = '{"qdrv", "rdrv", "rdlo"};

	seq_top i_dut (
		.dspif(dspif),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.qdrv(qdrv),
		.qdrv_stb(qdrv_stb),
		.rdrv(rdrv),
		.rdrv_stb(rdrv_stb),
		.rdlo(rdlo),
		.rdlo_stb(rdlo_stb)
	);

	always #10 dspif = ~dspif;

	function automatic int rnd_below(input int n);
		return {$random(seed)} % n;
	endfunction

	function automatic pulse_cmd_t make_pulse(input int ts, input int sel);
		pulse_cmd_t c;
		logic [31:0] rnd;
		c = '0;
		c.op = OP_PULSE;
		c.timestamp = ts;
		rnd = $random(seed);
		c.env_word = rnd[23:0];
		rnd = $random(seed);
		c.phase = rnd[16:0];
		c.freq = rnd[25:17];
		rnd = $random(seed);
		c.amp = rnd[15:0];
		c.cfg = {rnd[17:16], 2'(sel)};
		return c;
	endfunction

	// Element fields as the command layout defines them.
	function automatic logic [67:0] elem_fields(input pulse_cmd_t c, input int sel);
		qdrv_elem_t q;
		rdrv_elem_t r;
		q.mode = c.cfg[3:2];
		q.envstart = c.env_word[9:0];
		q.envlength = c.env_word[21:12];
		q.ampx = c.amp;
		q.freqaddr = c.freq;
		q.pini = c.phase;
		r.mode = c.cfg[3:2];
		r.envstart = c.env_word[11:0];
		r.envlength = c.env_word[23:12];
		r.ampx = c.amp;
		r.freqaddr = c.freq;
		r.pini = c.phase;
		return (sel == 0) ? {4'h0, q} : r;
	endfunction

	// Issue window per command: first data at 2 or 3, then 3 or 4 after each issue.
	function automatic void predict(input int core);
		pulse_cmd_t c;
		exp_t e;
		int min_iss;
		int max_iss;
		int lo;
		int hi;
		int ts;
		min_iss = 2;
		max_iss = 3;
		for (int k = 0; k < prog[core].size() && k < `CORE_REGION; k++) begin
			c = prog[core][k];
			if (c.op != OP_PULSE) break;
			ts = c.timestamp;
			lo = (ts > min_iss) ? ts : min_iss;
			hi = (ts > max_iss) ? ts : max_iss;
			if (c.cfg[1:0] != 2'd3) begin
				e.chan = c.cfg[1:0];
				e.data = elem_fields(c, c.cfg[1:0]);
				e.lo = lo + 1; // Router strobe trails the issue by one cycle.
				e.hi = hi + 1;
				exp_q[core].push_back(e);
			end
			min_iss = lo + 3;
			max_iss = hi + 4;
		end
	endfunction

	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr);
		@(posedge dspif);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge dspif);
		apb_req.penable <= 1'b1;
		@(negedge dspif);
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		if (!apb_rsp.pready) begin
			$display("APB access to %h got no pready", addr);
			errors++;
		end
		@(posedge dspif);
		apb_req <= '0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, wdata, rd, err);
	endtask

	task automatic load_all();
		logic [127:0] w;
		logic [11:0] addr;
		for (int i = 0; i < `N_CORES; i++) begin
			for (int k = 0; k < prog[i].size(); k++) begin
				w = prog[i][k];
				for (int lane = 0; lane < 4; lane++) begin
					addr = 12'((i * `CORE_REGION + k) * 16 + lane * 4);
					apb_write(addr, w[lane*32 +: 32]);
				end
			end
		end
	endtask

	task automatic start_run();
		apb_write(`CTRL_ADDR, 32'h1);
		start_cyc = cyc + 2; // Counter reads 0 two cycles after the access edge.
		repeat (2) @(posedge dspif);
	endtask

	task automatic wait_done();
		logic [31:0] rd;
		logic err;
		int polls;
		polls = 0;
		rd = '0;
		while (rd[`N_CORES-1:0] !== '1 && polls < POLL_LIMIT) begin
			apb_xfer(1'b0, `CTRL_ADDR, '0, rd, err);
			polls++;
		end
		if (rd[`N_CORES-1:0] !== '1) begin
			$display("cores did not halt within %0d control reads", POLL_LIMIT);
			errors++;
		end
		repeat (4) @(posedge dspif);
	endtask

	task automatic run_and_check();
		for (int i = 0; i < `N_CORES; i++) predict(i);
		start_run();
		wait_done();
	endtask

	task automatic begin_test();
		test_errors = errors;
		for (int i = 0; i < `N_CORES; i++) prog[i].delete();
	endtask

	task automatic end_test(input int num, input string name);
		for (int i = 0; i < `N_CORES; i++) begin
			if (exp_q[i].size() != 0) begin
				$display("core %0d: %0d expected strobes never came", i, exp_q[i].size());
				errors++;
				exp_q[i].delete();
			end
		end
		if (errors == test_errors) begin
			passed++;
			$display("test %0d %s: passed", num, name);
		end else begin
			$display("test %0d %s: failed", num, name);
		end
	endtask

	task automatic check_strobe(input int core, input int chan, input logic [67:0] got);
		exp_t e;
		int rel;
		int lo;
		int hi;
		rel = cyc - start_cyc;
		if (exp_q[core].size() == 0) begin
			$display("core %0d: unexpected %s strobe at cycle %0d", core, chan_name[chan], rel);
			errors++;
		end else begin
			e = exp_q[core].pop_front();
			lo = e.lo;
			hi = e.hi;
			if (e.chan != chan) begin
				$display("core %0d: %s strobed where %s was expected", core, chan_name[chan],
					chan_name[e.chan]);
				errors++;
			end else if (got !== e.data) begin
				$display("CHECK FAILED %s[%0d]: got %h expected %h", chan_name[chan], core,
					got, e.data);
				errors++;
			end
			if (rel < lo || rel > hi) begin
				$display("CHECK FAILED %s_stb[%0d] cycle: got %h expected %h to %h",
					chan_name[chan], core, rel, lo, hi);
				errors++;
			end
		end
	endtask

	// Outputs are sampled on the falling edge.
	always @(negedge dspif) begin
		cyc = cyc + 1;
		if (!reset) begin
			for (int i = 0; i < `N_CORES; i++) begin
				if (qdrv_stb[i]) check_strobe(i, 0, {4'h0, qdrv[i]});
				if (rdrv_stb[i]) check_strobe(i, 1, rdrv[i]);
				if (rdlo_stb[i]) check_strobe(i, 2, rdlo[i]);
			end
		end
	end

	initial begin
		#((10 + N_TESTS * (MAX_TS + 200)) * 20);
		$display("watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic err;
		seed = 32'hf4a2_312e;
		dspif = 1'b0;
		reset = 1'b1;
		apb_req = '0;
		cyc = 0;
		start_cyc = 0;
		errors = 0;
		passed = 0;
		repeat (10) @(posedge dspif);
		reset <= 1'b0;

		begin_test();
		repeat (20) @(posedge dspif);
		apb_xfer(1'b0, `CTRL_ADDR, '0, rd, err);
		if (rd[`N_CORES-1:0] !== '0) begin
			$display("CHECK FAILED done: got %h expected %h", rd[`N_CORES-1:0], 2'h0);
			errors++;
		end
		end_test(1, "idle after reset");

		begin_test();
		for (int k = 0; k < 8; k++) begin
			prog[0].push_back(make_pulse(12 + 16 * k + rnd_below(4), k % 3));
		end
		prog[0].push_back('0);
		prog[1].push_back('0);
		load_all();
		run_and_check();
		end_test(2, "core 0 alone");

		begin_test();
		for (int k = 0; k < 8; k++) begin
			prog[0].push_back(make_pulse(20 + 15 * k, rnd_below(3)));
			prog[1].push_back(make_pulse(20 + 15 * k, rnd_below(3)));
		end
		prog[0].push_back('0);
		prog[1].push_back('0);
		load_all();
		run_and_check();
		end_test(3, "both cores contending");

		begin_test();
		prog[0].push_back(make_pulse(0, 0)); // Already passed at start.
		prog[0].push_back(make_pulse(30, 3));
		prog[0].push_back(make_pulse(50, 1));
		prog[0].push_back(make_pulse(5, 2)); // Passed by the time it is fetched.
		prog[0].push_back(make_pulse(80, 3));
		prog[0].push_back(make_pulse(100, 0));
		prog[0].push_back('0);
		prog[1].push_back('0);
		load_all();
		run_and_check();
		end_test(4, "dropped and late pulses");

		begin_test();
		prog[0].push_back(make_pulse(20, 0));
		prog[0].push_back(make_pulse(40, 1));
		prog[0].push_back('0);
		prog[0].push_back(make_pulse(60, 2));
		prog[0].push_back(make_pulse(80, 0));
		prog[1].push_back(make_pulse(30, 2));
		prog[1].push_back('0);
		prog[1].push_back(make_pulse(50, 0));
		load_all();
		run_and_check();
		repeat (100) @(posedge dspif); // Past the timestamps behind the halts.
		end_test(5, "halt");

		test_errors = errors;
		apb_xfer(1'b0, 12'h404, '0, rd, err);
		if (err !== 1'b1) begin
			$display("CHECK FAILED pslverr: got %h expected %h", err, 1'b1);
			errors++;
		end
		apb_xfer(1'b1, 12'h7fc, 32'h1, rd, err);
		if (err !== 1'b1) begin
			$display("CHECK FAILED pslverr: got %h expected %h", err, 1'b1);
			errors++;
		end
		run_and_check();
		end_test(6, "slave error and replay");

		$display("%0d of %0d tests passed, %0d errors", passed, N_TESTS, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+design
design/pulse_pkg.sv
design/bus_pkg.sv
design/cmd_mem.sv
design/cmd_arbiter.sv
design/pulse_core.sv
design/elem_router.sv
design/seq_top.sv
verif/seq_tb.sv

// ==== Bender.yml ====
package:
  name: pulse_seq

sources:
  - include_dirs:
      - design
    files:
      - design/pulse_pkg.sv
      - design/bus_pkg.sv
      - design/cmd_mem.sv
      - design/cmd_arbiter.sv
      - design/pulse_core.sv
      - design/elem_router.sv
      - design/seq_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/seq_tb.sv
